/* design/ext_bus_drv.sv */
`timescale 1ns/1ns

module ext_bus_drv (
	input  logic                  gbclk,
	input  logic                  rst_n,
	input  logic                  bus_ready,
	input  logic                  emu_mbc,
	input  logic                  read,
	input  logic                  write,
	input  gb_bus_pkg::bus_data_t dout,
	input  gb_bus_pkg::region_e   region,
	input  gb_addr_pkg::ext_adr_t mapped_adr,
	input  logic                  sel_crom,
	input  logic                  sel_cram,
	output gb_addr_pkg::ext_adr_t ext_adr,
	output gb_bus_pkg::bus_data_t ext_dout,
	output logic                  ext_oe,
	output logic                  n_read,
	output logic                  n_write,
	output logic                  n_cs_ram,
	output logic                  n_cs_cart,
	output logic                  n_cs_crom,
	output logic                  n_cs_cram
);

	logic wr_q;       // Write seen in the previous cycle.
	logic ext_access; // Region lives on the external bus.
	logic rom_wr;
	logic cart_hit;

	assign ext_access = (region != gb_bus_pkg::REG_INT);
	assign cart_hit   = (region == gb_bus_pkg::REG_CROM) || (region == gb_bus_pkg::REG_CRAM);

	// Emulated MBC swallows ROM writes.
	assign rom_wr = emu_mbc && (region == gb_bus_pkg::REG_CROM);

	// ############################################################
	// Strobes and selects
	// ############################################################

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			wr_q      <= 1'b0;
			ext_oe    <= 1'b0;
			n_read    <= 1'b1;
			n_write   <= 1'b1;
			n_cs_ram  <= 1'b1;
			n_cs_cart <= 1'b1;
			n_cs_crom <= 1'b1;
			n_cs_cram <= 1'b1;
		end else begin
			wr_q <= write;
			// Data stays driven one cycle past the write.
			ext_oe    <= bus_ready && (write || wr_q);
			n_read    <= !(bus_ready && read && ext_access);
			n_write   <= !(bus_ready && write && ext_access && !rom_wr);
			n_cs_ram  <= !(bus_ready && (region == gb_bus_pkg::REG_WRAM));
			n_cs_cart <= !(bus_ready && cart_hit);
			n_cs_crom <= !(bus_ready && sel_crom);
			n_cs_cram <= !(bus_ready && sel_cram);
		end
	end

	// ############################################################
	// Address and data
	// ############################################################

	always_ff @(posedge gbclk) begin
		ext_adr  <= mapped_adr;
		ext_dout <= dout;
	end

endmodule

/* design/gb_addr_pkg.sv */
package gb_addr_pkg;

	// ############################################################
	// Address widths
	// ############################################################

	// Address as seen by the CPU.
	typedef logic [15:0] cpu_adr_t;

	// Flat external memory address, 2 MiB reach.
	typedef logic [20:0] ext_adr_t;

	// ############################################################
	// Bank registers
	// ############################################################

	// Low ROM bank, selects a 16 KiB window.
	typedef logic [4:0] rom_bank_t;

	typedef logic [1:0] hi_bank_t; // Upper ROM bits or RAM bank.

endpackage

/* design/gb_bus_defines.svh */
`ifndef GB_BUS_DEFINES_SVH
`define GB_BUS_DEFINES_SVH

// ############################################################
// Reset sequencing
// ############################################################

// Cycles after reset release before the bus may be used.
`define GB_RESET_TICKS 16

// ############################################################
// Bank controller and pin widths
// ############################################################

`define GB_RAM_ENABLE_KEY 4'hA // Low nibble that unlocks cart RAM.

`define GB_CPU_ADR_W 16
`define GB_EXT_ADR_W 21 // Flat external address.

`endif

/* design/gb_bus_pkg.sv */
package gb_bus_pkg;

	// ############################################################
	// Bus payload
	// ############################################################

	typedef logic [7:0] bus_data_t; // One data byte.

	// ############################################################
	// Memory map
	// ############################################################

	// Regions of the console memory map.
	typedef enum logic [1:0] {
		REG_CROM = 2'd0, // Cartridge ROM and bank registers.
		REG_INT  = 2'd1, // VRAM, OAM, I/O, HRAM.
		REG_CRAM = 2'd2, // Cartridge RAM.
		REG_WRAM = 2'd3  // Work RAM and its echo.
	} region_e;

	// ############################################################
	// Reset sequencer
	// ############################################################

	typedef enum logic [1:0] {
		RS_HOLD  = 2'd0,
		RS_COUNT = 2'd1,
		RS_DONE  = 2'd2
	} rst_state_e;

endpackage

/* design/gb_cart_bus.sv */
`timescale 1ns/1ns

module gb_cart_bus (
	input  logic                  gbclk,
	input  logic                  rst_n,
	input  gb_addr_pkg::cpu_adr_t adr,
	input  gb_bus_pkg::bus_data_t dout,
	input  logic                  read,
	input  logic                  write,
	input  logic                  emu_mbc,   // Emulate the cartridge MBC.
	output gb_addr_pkg::ext_adr_t ext_adr,
	output gb_bus_pkg::bus_data_t ext_dout,
	output logic                  ext_oe,
	output logic                  n_read,
	output logic                  n_write,
	output logic                  n_cs_ram,  // Work RAM.
	output logic                  n_cs_cart, // Cartridge slot.
	output logic                  n_cs_crom, // Cart ROM, emulate mode only.
	output logic                  n_cs_cram, // Cart RAM, emulate mode only.
	output logic                  bus_ready
);

	gb_bus_pkg::region_e   region;
	gb_addr_pkg::ext_adr_t mapped_adr;
	logic                  sel_crom;
	logic                  sel_cram;

	gb_reset_seq seq0 (
		.gbclk     (gbclk),
		.rst_n     (rst_n),
		.bus_ready (bus_ready)
	);

	gb_memmap map0 (
		.adr    (adr),
		.region (region)
	);

	mbc_chip mbc0 (
		.gbclk      (gbclk),
		.rst_n      (rst_n),
		.emu_mbc    (emu_mbc),
		.write      (write),
		.adr        (adr),
		.dout       (dout),
		.region     (region),
		.mapped_adr (mapped_adr),
		.sel_crom   (sel_crom),
		.sel_cram   (sel_cram)
	);

	ext_bus_drv drv0 (
		.gbclk      (gbclk),
		.rst_n      (rst_n),
		.bus_ready  (bus_ready),
		.emu_mbc    (emu_mbc),
		.read       (read),
		.write      (write),
		.dout       (dout),
		.region     (region),
		.mapped_adr (mapped_adr),
		.sel_crom   (sel_crom),
		.sel_cram   (sel_cram),
		.ext_adr    (ext_adr),
		.ext_dout   (ext_dout),
		.ext_oe     (ext_oe),
		.n_read     (n_read),
		.n_write    (n_write),
		.n_cs_ram   (n_cs_ram),
		.n_cs_cart  (n_cs_cart),
		.n_cs_crom  (n_cs_crom),
		.n_cs_cram  (n_cs_cram)
	);

endmodule

/* design/gb_memmap.sv */
`timescale 1ns/1ns

module gb_memmap (
	input  gb_addr_pkg::cpu_adr_t adr,
	output gb_bus_pkg::region_e   region
);

	// ############################################################
	// Region boundaries
	// ############################################################

	localparam gb_addr_pkg::cpu_adr_t VRAM_BASE = 16'h8000; // End of cart ROM.
	localparam gb_addr_pkg::cpu_adr_t CRAM_BASE = 16'hA000;
	localparam gb_addr_pkg::cpu_adr_t WRAM_BASE = 16'hC000;
	localparam gb_addr_pkg::cpu_adr_t OAM_BASE  = 16'hFE00; // Echo ends here.

	// ############################################################
	// Priority decode
	// ############################################################

	// Ranges are tested low to high, first match wins.
	always_comb begin
		if (adr < VRAM_BASE) begin
			region = gb_bus_pkg::REG_CROM;
		end else if (adr < CRAM_BASE) begin
			region = gb_bus_pkg::REG_INT; // VRAM stays on the video side.
		end else if (adr < WRAM_BASE) begin
			region = gb_bus_pkg::REG_CRAM;
		end else if (adr < OAM_BASE) begin
			// E000-FDFF mirrors work RAM.
			region = gb_bus_pkg::REG_WRAM;
		end else begin
			region = gb_bus_pkg::REG_INT; // OAM, I/O, HRAM, IE.
		end
	end

endmodule

/* design/gb_reset_seq.sv */
`timescale 1ns/1ns
`include "gb_bus_defines.svh"

module gb_reset_seq (
	input  logic gbclk,
	input  logic rst_n,
	output logic bus_ready
);

	localparam int TICK_W = $clog2(`GB_RESET_TICKS);

	gb_bus_pkg::rst_state_e state;
	logic [TICK_W-1:0]      ticks;

	// ############################################################
	// Settle counter
	// ############################################################

	// Counting starts on the first edge out of reset, so the
	// last tick lands exactly GB_RESET_TICKS edges later.
	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			state <= gb_bus_pkg::RS_HOLD;
			ticks <= '0;
		end else begin
			case (state)
				gb_bus_pkg::RS_HOLD: begin
					state <= gb_bus_pkg::RS_COUNT;
					ticks <= '0;
				end
				gb_bus_pkg::RS_COUNT: begin
					if (ticks == TICK_W'(`GB_RESET_TICKS - 1))
						state <= gb_bus_pkg::RS_DONE;
					else
						ticks <= ticks + 1'b1;
				end
				gb_bus_pkg::RS_DONE: begin
					state <= gb_bus_pkg::RS_DONE; // Sticky until next reset.
				end
				default: begin
					state <= gb_bus_pkg::RS_HOLD;
				end
			endcase
		end
	end

	assign bus_ready = (state == gb_bus_pkg::RS_DONE);

endmodule

/* design/mbc_chip.sv */
`timescale 1ns/1ns
`include "gb_bus_defines.svh"

module mbc_chip (
	input  logic                  gbclk,
	input  logic                  rst_n,
	input  logic                  emu_mbc,
	input  logic                  write,
	input  gb_addr_pkg::cpu_adr_t adr,
	input  gb_bus_pkg::bus_data_t dout,
	input  gb_bus_pkg::region_e   region,
	output gb_addr_pkg::ext_adr_t mapped_adr,
	output logic                  sel_crom,
	output logic                  sel_cram
);

	localparam int PAD_W     = `GB_EXT_ADR_W - `GB_CPU_ADR_W;
	localparam int RAM_PAD_W = `GB_EXT_ADR_W - 15; // Above bank and 8 KiB offset.

	gb_addr_pkg::rom_bank_t rom_bank;
	gb_addr_pkg::hi_bank_t  hi_bank;
	gb_addr_pkg::hi_bank_t  mode_bank;
	logic                   mode;
	logic                   ram_en;
	logic                   bank_wr;

	// ############################################################
	// Bank registers
	// ############################################################

	// Writes into the ROM area never reach memory, they land here.
	assign bank_wr = emu_mbc && write && (region == gb_bus_pkg::REG_CROM);

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			rom_bank <= gb_addr_pkg::rom_bank_t'(1);
			hi_bank  <= '0;
			mode     <= 1'b0;
			ram_en   <= 1'b0;
		end else if (bank_wr) begin
			case (adr[14:13])
				2'b00: begin
					ram_en <= (dout[3:0] == `GB_RAM_ENABLE_KEY);
				end
				2'b01: begin
					// Bank 0 is not reachable in the upper window.
					if (dout[4:0] == 5'd0)
						rom_bank <= gb_addr_pkg::rom_bank_t'(1);
					else
						rom_bank <= dout[4:0];
				end
				2'b10: begin
					hi_bank <= dout[1:0];
				end
				default: begin
					mode <= dout[0];
				end
			endcase
		end
	end

	// ############################################################
	// Address translation
	// ############################################################

	// Mode 1 lets hi_bank reach the lower ROM window and cart RAM.
	assign mode_bank = mode ? hi_bank : 2'b00;

	always_comb begin
		mapped_adr = {{PAD_W{1'b0}}, adr}; // Pass-through default.
		if (emu_mbc) begin
			if (region == gb_bus_pkg::REG_CROM) begin
				if (adr[14])
					mapped_adr = {hi_bank, rom_bank, adr[13:0]};
				else
					mapped_adr = {mode_bank, 5'd0, adr[13:0]};
			end else if (region == gb_bus_pkg::REG_CRAM) begin
				mapped_adr = {{RAM_PAD_W{1'b0}}, mode_bank, adr[12:0]};
			end
		end
	end

	// ############################################################
	// Cartridge selects
	// ############################################################

	assign sel_crom = emu_mbc && (region == gb_bus_pkg::REG_CROM);
	assign sel_cram = emu_mbc && ram_en && (region == gb_bus_pkg::REG_CRAM);

endmodule

/* tb/gb_cart_bus_properties.sv */
`timescale 1ns/1ns

module gb_cart_bus_properties (
	input logic                  gbclk,
	input logic                  rst_n,
	input logic                  bus_ready,
	input logic                  emu_mbc,
	input logic                  write,
	input gb_addr_pkg::cpu_adr_t adr,
	input gb_bus_pkg::bus_data_t dout,
	input gb_bus_pkg::bus_data_t ext_dout,
	input logic                  ext_oe,
	input logic                  n_read,
	input logic                  n_write,
	input logic                  n_cs_ram,
	input logic                  n_cs_cart,
	input logic                  n_cs_crom,
	input logic                  n_cs_cram
);

	int   fail_count = 0;
	logic int_hit;
	logic all_idle;

	assign int_hit  = ((adr >= 16'h8000) && (adr < 16'hA000)) || (adr >= 16'hFE00);
	assign all_idle = n_read && n_write && n_cs_ram && n_cs_cart && n_cs_crom && n_cs_cram;

	// ############################################################
	// Reset quiet period
	// ############################################################

	quiet_a: assert property (@(posedge gbclk) disable iff (!rst_n)
		!bus_ready |-> (all_idle && !ext_oe))
	else begin
		$error("bus pins active before bus_ready");
		fail_count++;
	end

	// ############################################################
	// Strobes and write path
	// ############################################################

	rom_wr_a: assert property (@(posedge gbclk) disable iff (!rst_n)
		(emu_mbc && write && (adr < 16'h8000)) |=> n_write)
	else begin
		$error("n_write pulled low by an emulated ROM write");
		fail_count++;
	end

	int_quiet_a: assert property (@(posedge gbclk) disable iff (!rst_n)
		(bus_ready && int_hit) |=> all_idle)
	else begin
		$error("internal region access produced an external strobe");
		fail_count++;
	end

	data_a: assert property (@(posedge gbclk) disable iff (!rst_n)
		(bus_ready && write) |=> (ext_oe && (ext_dout == $past(dout))))
	else begin
		$error("write data not driven on ext_dout");
		fail_count++;
	end

	oe_hold_a: assert property (@(posedge gbclk) disable iff (!rst_n)
		(bus_ready && $fell(write)) |=> ext_oe)
	else begin
		$error("ext_oe not held one cycle after write");
		fail_count++;
	end

	oe_drop_a: assert property (@(posedge gbclk) disable iff (!rst_n)
		(bus_ready && !write && !$past(write)) |=> !ext_oe)
	else begin
		$error("ext_oe held longer than one cycle after write");
		fail_count++;
	end

endmodule

bind gb_cart_bus gb_cart_bus_properties props0 (
	.gbclk     (gbclk),
	.rst_n     (rst_n),
	.bus_ready (bus_ready),
	.emu_mbc   (emu_mbc),
	.write     (write),
	.adr       (adr),
	.dout      (dout),
	.ext_dout  (ext_dout),
	.ext_oe    (ext_oe),
	.n_read    (n_read),
	.n_write   (n_write),
	.n_cs_ram  (n_cs_ram),
	.n_cs_cart (n_cs_cart),
	.n_cs_crom (n_cs_crom),
	.n_cs_cram (n_cs_cram)
);

/* tb/tb_gb_cart_bus.sv */
`timescale 1ns/1ns
`include "gb_bus_defines.svh"

module tb_gb_cart_bus;

	localparam int READY_LIMIT = 64;

	logic                  gbclk;
	logic                  rst_n;
	gb_addr_pkg::cpu_adr_t adr;
	gb_bus_pkg::bus_data_t dout;
	logic                  read;
	logic                  write;
	logic                  emu_mbc;
	gb_addr_pkg::ext_adr_t ext_adr;
	gb_bus_pkg::bus_data_t ext_dout;
	logic                  ext_oe;
	logic                  n_read;
	logic                  n_write;
	logic                  n_cs_ram;
	logic                  n_cs_cart;
	logic                  n_cs_crom;
	logic                  n_cs_cram;
	logic                  bus_ready;

	gb_addr_pkg::rom_bank_t m_rom; // Model of the bank registers.
	gb_addr_pkg::hi_bank_t  m_hi;
	logic                   m_mode;
	logic                   m_ram_en;
	logic                   m_wr_q;
	int                     m_edges; // Edges since reset release.

	int     check_errors;
	int     timeout_errors;
	integer seed;

	initial begin
		gbclk = 1'b0;
		forever #10 gbclk = ~gbclk;
	end

	gb_cart_bus dut0 (.*);

	// ############################################################
	// Reference model
	// ############################################################

	function automatic gb_bus_pkg::region_e region_of(input gb_addr_pkg::cpu_adr_t a);
		if (a <= 16'h7FFF)
			return gb_bus_pkg::REG_CROM;
		if (a <= 16'h9FFF)
			return gb_bus_pkg::REG_INT;
		if (a <= 16'hBFFF)
			return gb_bus_pkg::REG_CRAM;
		if (a <= 16'hFDFF)
			return gb_bus_pkg::REG_WRAM; // Echo included.
		return gb_bus_pkg::REG_INT;
	endfunction

	function automatic gb_addr_pkg::ext_adr_t model_adr(input gb_addr_pkg::cpu_adr_t a,
			input logic emu);
		gb_bus_pkg::region_e   r;
		gb_addr_pkg::hi_bank_t top;
		r   = region_of(a);
		top = m_mode ? m_hi : 2'b00;
		if (emu && (r == gb_bus_pkg::REG_CROM)) begin
			if (a < 16'h4000)
				return {top, 5'd0, a[13:0]};
			return {m_hi, m_rom, a[13:0]};
		end
		if (emu && (r == gb_bus_pkg::REG_CRAM))
			return {6'd0, top, a[12:0]};
		return {5'd0, a};
	endfunction

	task automatic check_val(input string name, input logic [20:0] exp, input logic [20:0] got);
		assert (got === exp) else begin
			$display("CHECK FAILED t=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
			check_errors++;
		end
	endtask

	// One CPU cycle of drive, predict and compare after the edge.
	task automatic run_cycle(input gb_addr_pkg::cpu_adr_t a, input gb_bus_pkg::bus_data_t d,
			input logic rd, input logic wr, input logic emu);
		gb_bus_pkg::region_e   r;
		gb_addr_pkg::ext_adr_t e_adr;
		logic                  rdy;
		logic                  ext;
		logic                  e_oe;
		logic                  e_nrd;
		logic                  e_nwr;
		logic                  e_ram;
		logic                  e_cart;
		logic                  e_crom;
		logic                  e_cram;
		adr     = a;
		dout    = d;
		read    = rd;
		write   = wr;
		emu_mbc = emu;
		r       = region_of(a);
		rdy     = (m_edges > `GB_RESET_TICKS);
		ext     = (r != gb_bus_pkg::REG_INT);
		e_adr   = model_adr(a, emu);
		e_oe    = rdy && (wr || m_wr_q);
		e_nrd   = !(rdy && rd && ext);
		e_nwr   = !(rdy && wr && ext && !(emu && (r == gb_bus_pkg::REG_CROM)));
		e_ram   = !(rdy && (r == gb_bus_pkg::REG_WRAM));
		e_cart  = !(rdy && ((r == gb_bus_pkg::REG_CROM) || (r == gb_bus_pkg::REG_CRAM)));
		e_crom  = !(rdy && emu && (r == gb_bus_pkg::REG_CROM));
		e_cram  = !(rdy && emu && m_ram_en && (r == gb_bus_pkg::REG_CRAM));
		// Bank register writes take effect after this edge.
		if (emu && wr && (r == gb_bus_pkg::REG_CROM)) begin
			if (a < 16'h2000)
				m_ram_en = (d[3:0] == `GB_RAM_ENABLE_KEY);
			else if (a < 16'h4000)
				m_rom = (d[4:0] == 5'd0) ? 5'd1 : d[4:0];
			else if (a < 16'h6000)
				m_hi = d[1:0];
			else
				m_mode = d[0];
		end
		m_wr_q = wr;
		m_edges++;
		@(posedge gbclk);
		@(negedge gbclk);
		check_val("ext_adr", e_adr, ext_adr);
		check_val("ext_dout", d, ext_dout);
		check_val("ext_oe", e_oe, ext_oe);
		check_val("n_read", e_nrd, n_read);
		check_val("n_write", e_nwr, n_write);
		check_val("n_cs_ram", e_ram, n_cs_ram);
		check_val("n_cs_cart", e_cart, n_cs_cart);
		check_val("n_cs_crom", e_crom, n_cs_crom);
		check_val("n_cs_cram", e_cram, n_cs_cram);
		check_val("bus_ready", m_edges > `GB_RESET_TICKS, bus_ready);
	endtask

	task automatic read_at(input gb_addr_pkg::cpu_adr_t a, input logic emu);
		run_cycle(a, 8'h00, 1'b1, 1'b0, emu);
	endtask

	task automatic write_at(input gb_addr_pkg::cpu_adr_t a, input gb_bus_pkg::bus_data_t d,
			input logic emu);
		run_cycle(a, d, 1'b0, 1'b1, emu);
	endtask

	task automatic idle_cycles(input int n, input logic emu);
		repeat (n) run_cycle(16'hC000, 8'h00, 1'b0, 1'b0, emu);
	endtask

	task automatic apply_reset;
		rst_n = 1'b0;
		repeat (5) @(posedge gbclk);
		@(negedge gbclk);
		rst_n    = 1'b1;
		m_rom    = 5'd1;
		m_hi     = 2'b00;
		m_mode   = 1'b0;
		m_ram_en = 1'b0;
		m_wr_q   = 1'b0;
		m_edges  = 0;
	endtask

	// ############################################################
	// Stimulus
	// ############################################################

	initial begin
		int                    n;
		int                    kind;
		gb_addr_pkg::cpu_adr_t ra;
		gb_bus_pkg::bus_data_t rd;
		logic                  emu;
		rst_n          = 1'b0;
		adr            = '0;
		dout           = '0;
		read           = 1'b0;
		write          = 1'b0;
		emu_mbc        = 1'b0;
		check_errors   = 0;
		timeout_errors = 0;
		seed           = 32'hb7ac_a496;
		apply_reset();

		// Traffic during the settle period must stay off the pins.
		n = 0;
		do begin
			if (n % 2)
				write_at(gb_addr_pkg::cpu_adr_t'(16'hC000 + n), 8'(n), 1'b1);
			else
				read_at(gb_addr_pkg::cpu_adr_t'(16'hC100 + n), 1'b1);
			n++;
		end while (!bus_ready && (n < READY_LIMIT));
		if (!bus_ready) begin
			$display("timeout: bus_ready did not rise within %0d cycles", READY_LIMIT);
			timeout_errors++;
		end else begin
			assert (n - 1 == `GB_RESET_TICKS) else begin
				$display("CHECK FAILED t=%0t bus_ready_delay expected=%0d actual=%0d",
					$time, `GB_RESET_TICKS, n - 1);
				check_errors++;
			end
		end

		// Pass-through over every region.
		read_at(16'h0150, 1'b0);
		write_at(16'h4567, 8'h11, 1'b0);
		read_at(16'h8123, 1'b0);
		write_at(16'h9000, 8'h22, 1'b0);
		read_at(16'hA010, 1'b0);
		write_at(16'hB7FF, 8'h33, 1'b0);
		read_at(16'hC234, 1'b0);
		write_at(16'hE800, 8'h44, 1'b0); // Echo area.
		read_at(16'hFE00, 1'b0);
		write_at(16'hFF80, 8'h55, 1'b0);
		idle_cycles(2, 1'b0);

		// ROM banking with bank zero mapped to one.
		write_at(16'h2000, 8'h00, 1'b1);
		read_at(16'h4123, 1'b1);
		write_at(16'h2100, 8'h13, 1'b1);
		read_at(16'h7FFF, 1'b1);
		write_at(16'h3000, 8'h20, 1'b1);
		read_at(16'h5555, 1'b1);
		write_at(16'h4000, 8'h02, 1'b1);
		read_at(16'h6000, 1'b1);
		read_at(16'h0123, 1'b1);
		write_at(16'h6000, 8'h01, 1'b1); // Mode 1.
		read_at(16'h0123, 1'b1);
		read_at(16'h3FFF, 1'b1);
		write_at(16'h7000, 8'h00, 1'b1);
		read_at(16'h0123, 1'b1);

		// Cartridge RAM gating and bank.
		read_at(16'hA000, 1'b1);
		write_at(16'h0000, 8'h0A, 1'b1);
		read_at(16'hA123, 1'b1);
		write_at(16'h4000, 8'h03, 1'b1);
		read_at(16'hBFFF, 1'b1);
		write_at(16'h6000, 8'h01, 1'b1);
		read_at(16'hBFFF, 1'b1);
		write_at(16'hA456, 8'h77, 1'b1);
		write_at(16'h1000, 8'h05, 1'b1);
		read_at(16'hA000, 1'b1);

		// Write path and output-enable hold.
		write_at(16'h2000, 8'h04, 1'b1);
		idle_cycles(2, 1'b1);
		write_at(16'hC000, 8'h5A, 1'b1);
		idle_cycles(3, 1'b1);
		write_at(16'hC001, 8'hA5, 1'b1);
		write_at(16'hD002, 8'h3C, 1'b1);
		read_at(16'hC003, 1'b1);
		write_at(16'hC004, 8'hC3, 1'b1);
		idle_cycles(2, 1'b1);

		// ############################################################
		// Random mixed traffic
		// ############################################################

		for (int i = 0; i < 400; i++) begin
			emu  = ((i / 100) % 2 == 0);
			ra   = gb_addr_pkg::cpu_adr_t'($random(seed));
			rd   = gb_bus_pkg::bus_data_t'($random(seed));
			kind = {$random(seed)} % 4;
			case (kind)
				0: idle_cycles(1, emu);
				1: read_at(ra, emu);
				2: write_at(ra, rd, emu);
				default: begin
					if (rd[7])
						rd = {rd[7:4], 4'hA}; // Hit the RAM key now and then.
					write_at({1'b0, ra[14:0]}, rd, emu);
				end
			endcase
		end
		idle_cycles(2, 1'b1);

		$display("errors: check=%0d timeout=%0d property=%0d",
			check_errors, timeout_errors, dut0.props0.fail_count);
		if (check_errors + timeout_errors + dut0.props0.fail_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+design
design/gb_addr_pkg.sv
design/gb_bus_pkg.sv
design/gb_reset_seq.sv
design/gb_memmap.sv
design/mbc_chip.sv
design/ext_bus_drv.sv
design/gb_cart_bus.sv
tb/gb_cart_bus_properties.sv
tb/tb_gb_cart_bus.sv
